//--- Bender.yml
package:
  name: gb_cart

export_include_dirs:
  - src

sources:
  - src/gb_cart_pkg.sv
  - src/cart_header.sv
  - src/mbc_ctrl.sv
  - src/rom_bank_map.sv
  - src/cart_ram.sv
  - src/mbc3_rtc.sv
  - src/gb_cart.sv
  - target: test
    files:
      - tests/tb_gb_cart.sv

//--- gb_cart.f
+incdir+src
src/gb_cart_pkg.sv
src/cart_header.sv
src/mbc_ctrl.sv
src/rom_bank_map.sv
src/cart_ram.sv
src/mbc3_rtc.sv
src/gb_cart.sv
tests/tb_gb_cart.sv

//--- src/cart_header.sv
// cartridge header capture from the download stream,
// mapper kind and rom / ram bank mask decode

`timescale 1ns/100ps
`include "gb_cart_consts.svh"
`default_nettype none

module cart_header (
	input  wire                    clk_sys,
	input  wire                    dl_active,
	input  wire                    dl_wr,
	input  wire  [23:0]            dl_addr,
	input  wire  [15:0]            dl_data,
	output gb_cart_pkg::mbc_kind_t mbc_kind,
	output gb_cart_pkg::rom_bank_t rom_mask,
	output gb_cart_pkg::ram_bank_t ram_mask,
	output logic                   has_ram
);
	import gb_cart_pkg::*;

	logic [7:0] type_byte;
	logic [7:0] rom_code;
	logic [7:0] ram_code;

	// header bytes are kept until the next download
	always_ff @(posedge clk_sys) begin
		if (dl_active && dl_wr) begin
			if (dl_addr == `HDR_TYPE_ADDR)
				type_byte <= dl_data[15:8];
			if (dl_addr == `HDR_SIZE_ADDR) begin
				rom_code <= dl_data[7:0];
				ram_code <= dl_data[15:8];
			end
		end
	end

	always_comb begin
		case (type_byte) inside
			[8'h01:8'h03]: mbc_kind = kind_mbc1;
			[8'h05:8'h06]: mbc_kind = kind_mbc2;
			[8'h0F:8'h13]: mbc_kind = kind_mbc3;    // 0F and 10 carry the clock
			[8'h19:8'h1E]: mbc_kind = kind_mbc5;
			default:       mbc_kind = kind_none;
		endcase
	end

	// 2^(n+1) banks, the odd sized carts round up to 128
	always_comb begin
		if (rom_code <= 8'd8)
			rom_mask = rom_bank_t'((10'd2 << rom_code[3:0]) - 10'd1);
		else if (rom_code inside {[8'h52:8'h54]})
			rom_mask = 9'h07F;
		else
			rom_mask = 9'h1FF;
	end

	always_comb begin
		case (ram_code)
			8'd3:    ram_mask = 4'h3;    // 32 KB
			8'd4:    ram_mask = 4'hF;    // 128 KB
			8'd5:    ram_mask = 4'h7;    // 64 KB
			default: ram_mask = 4'h0;    // none, 2 KB or 8 KB
		endcase
	end

	assign has_ram = (ram_code != 8'd0) || (mbc_kind == kind_mbc2);    // mbc2 ram sits in the chip

endmodule

`default_nettype wire

//--- src/cart_ram.sv
// banked cartridge ram and the cart_do read mux
// for rom bytes, ram, mbc2 nibbles and clock registers

`timescale 1ns/100ps
`include "gb_cart_consts.svh"
`default_nettype none

module cart_ram (
	input  wire                          clk_sys,
	input  wire                          ce,
	input  wire gb_cart_pkg::cart_addr_t cart_addr,
	input  wire                          cart_rd,
	input  wire                          cart_wr,
	input  wire  [7:0]                   cart_di,
	input  wire gb_cart_pkg::ram_bank_t  ram_bank,
	input  wire gb_cart_pkg::ram_bank_t  ram_mask,
	input  wire gb_cart_pkg::mbc_kind_t  mbc_kind,
	input  wire                          mbc1_mode,
	input  wire                          ram_enable,
	input  wire                          rtc_mode,
	input  wire                          has_ram,
	input  wire  [15:0]                  rom_data,
	input  wire  [7:0]                   rtc_data,
	output logic [7:0]                   cart_do
);
	import gb_cart_pkg::*;

	logic [7:0]  ram_mem [0:(1 << 17) - 1];    // 16 banks of 8 KB
	logic [7:0]  ram_q;
	logic [7:0]  cram_do;
	logic [16:0] ram_addr;
	logic [12:0] offset;
	ram_bank_t   bank_sel;
	logic        cram_sel;
	logic        ram_wr;
	logic        is_mbc2;

	assign is_mbc2  = (mbc_kind == kind_mbc2);
	assign cram_sel = (cart_addr[15:13] == `REGION_CRAM);

	always_comb begin
		case (mbc_kind)
			kind_mbc1:  bank_sel = mbc1_mode ? ram_bank : 4'd0;
			kind_mbc3,
			kind_mbc5:  bank_sel = ram_bank;
			default:    bank_sel = 4'd0;
		endcase
	end

	assign offset   = is_mbc2 ? {4'd0, cart_addr[8:0]} : cart_addr[12:0];    // 512 cells, mirrored
	assign ram_addr = {bank_sel & ram_mask, offset};
	assign ram_wr   = ce && cart_wr && cram_sel && ram_enable && !rtc_mode && has_ram;

	// --------------------
	always_ff @(posedge clk_sys) begin
		if (ram_wr)
			ram_mem[ram_addr] <= cart_di;
		if (cart_rd)
			ram_q <= ram_mem[ram_addr];
	end

	always_comb begin
		if (!ram_enable)
			cram_do = 8'hFF;
		else if (rtc_mode)
			cram_do = rtc_data;
		else if (!has_ram)
			cram_do = 8'hFF;    // nothing answers on the bus
		else if (is_mbc2)
			cram_do = {4'hF, ram_q[3:0]};
		else
			cram_do = ram_q;
	end

	// rom words hold two bytes, bit 0 picks one
	assign cart_do = cram_sel ? cram_do : (cart_addr[0] ? rom_data[15:8] : rom_data[7:0]);

endmodule

`default_nettype wire

//--- src/gb_cart.sv
// cartridge mapper top: header decode, mapper control,
// rom mapping, cartridge ram and mbc3 clock

`timescale 1ns/100ps
`include "gb_cart_consts.svh"
`default_nettype none

module gb_cart #(
	parameter int tick_cycles = `RTC_TICK_CYCLES
) (
	input  wire                          clk_sys,
	input  wire                          reset,
	input  wire                          ce,
	input  wire gb_cart_pkg::cart_addr_t cart_addr,
	input  wire                          cart_rd,
	input  wire                          cart_wr,
	input  wire  [7:0]                   cart_di,
	input  wire  [15:0]                  rom_data,
	input  wire                          dl_active,
	input  wire                          dl_wr,
	input  wire  [23:0]                  dl_addr,
	input  wire  [15:0]                  dl_data,
	output gb_cart_pkg::rom_addr_t       rom_addr,
	output logic                         rom_rd,
	output logic [7:0]                   cart_do
);
	import gb_cart_pkg::*;

	mbc_kind_t  mbc_kind;
	rom_bank_t  rom_mask, rom_bank;
	ram_bank_t  ram_mask, ram_bank;
	logic       has_ram, mbc1_mode, ram_enable, rtc_mode;
	rtc_sel_t   rtc_index;
	logic       rtc_index_wr;
	logic [7:0] rtc_data;

	cart_header i_header (
		.clk_sys(clk_sys), .dl_active(dl_active), .dl_wr(dl_wr), .dl_addr(dl_addr),
		.dl_data(dl_data), .mbc_kind(mbc_kind), .rom_mask(rom_mask),
		.ram_mask(ram_mask), .has_ram(has_ram)
	);

	mbc_ctrl i_ctrl (
		.clk_sys(clk_sys), .reset(reset), .ce(ce), .cart_addr(cart_addr),
		.cart_wr(cart_wr), .cart_di(cart_di), .mbc_kind(mbc_kind),
		.rom_bank(rom_bank), .ram_bank(ram_bank), .mbc1_mode(mbc1_mode),
		.ram_enable(ram_enable), .rtc_mode(rtc_mode), .rtc_index(rtc_index),
		.rtc_index_wr(rtc_index_wr)
	);

	rom_bank_map i_rom_map (
		.cart_addr(cart_addr), .cart_rd(cart_rd), .rom_bank(rom_bank),
		.ram_bank(ram_bank), .rom_mask(rom_mask), .ram_mask(ram_mask),
		.mbc_kind(mbc_kind), .mbc1_mode(mbc1_mode), .rom_addr(rom_addr), .rom_rd(rom_rd)
	);

	cart_ram i_ram (
		.clk_sys(clk_sys), .ce(ce), .cart_addr(cart_addr), .cart_rd(cart_rd),
		.cart_wr(cart_wr), .cart_di(cart_di), .ram_bank(ram_bank), .ram_mask(ram_mask),
		.mbc_kind(mbc_kind), .mbc1_mode(mbc1_mode), .ram_enable(ram_enable),
		.rtc_mode(rtc_mode), .has_ram(has_ram), .rom_data(rom_data),
		.rtc_data(rtc_data), .cart_do(cart_do)
	);

	mbc3_rtc #(.tick_cycles(tick_cycles)) i_rtc (
		.clk_sys(clk_sys), .reset(reset), .ce(ce), .cart_addr(cart_addr),
		.cart_wr(cart_wr), .cart_di(cart_di), .rtc_mode(rtc_mode),
		.rtc_index(rtc_index), .rtc_index_wr(rtc_index_wr), .rtc_data(rtc_data)
	);

endmodule

`default_nettype wire

//--- src/gb_cart_consts.svh
// bus region codes, header offsets, RAM enable key
// and RTC limits for the cartridge mapper

`ifndef GB_CART_CONSTS_SVH
`define GB_CART_CONSTS_SVH

// --------------------
// cart_addr[15:13] regions
`define REGION_RAM_EN   3'd0    // 0000-1FFF
`define REGION_ROM_BANK 3'd1    // 2000-3FFF
`define REGION_RAM_BANK 3'd2    // 4000-5FFF
`define REGION_MODE     3'd3    // 6000-7FFF
`define REGION_CRAM     3'd5    // A000-BFFF

// --------------------
// header words in the download stream, byte addressed
`define HDR_TYPE_ADDR 24'h000146    // high byte is the cart type
`define HDR_SIZE_ADDR 24'h000148    // low rom size, high ram size

// low nibble written to 0000-1FFF that opens the RAM
`define RAM_ENABLE_KEY 4'hA

// --------------------
// clock limits
`define RTC_TICK_CYCLES 33554432    // 2^25 system cycles per second
`define RTC_MAX_DAYS    10'd512

`endif

//--- src/gb_cart_pkg.sv
// mapper kind, bank number, cartridge address
// and RTC field types shared by the mapper

`default_nettype none

package gb_cart_pkg;

	// --------------------
	// mapper decoded from the cart type byte
	typedef enum logic [2:0] {
		kind_none = 3'd0,
		kind_mbc1 = 3'd1,
		kind_mbc2 = 3'd2,
		kind_mbc3 = 3'd3,
		kind_mbc5 = 3'd4
	} mbc_kind_t;

	typedef logic [8:0]  rom_bank_t;    // 16 KB bank, up to 512
	typedef logic [3:0]  ram_bank_t;    // 8 KB bank, up to 16
	typedef logic [15:0] cart_addr_t;   // cpu side
	typedef logic [22:0] rom_addr_t;    // byte address into external memory

	// --------------------
	// clock register index as written to 4000-5FFF
	typedef enum logic [2:0] {
		sel_sec    = 3'd0,
		sel_min    = 3'd1,
		sel_hour   = 3'd2,
		sel_day_lo = 3'd3,
		sel_day_hi = 3'd4
	} rtc_sel_t;

	typedef logic [5:0] rtc_sec_t;    // seconds and minutes
	typedef logic [4:0] rtc_hour_t;
	typedef logic [9:0] rtc_day_t;    // one spare bit catches day 512

endpackage

`default_nettype wire

//--- src/mbc3_rtc.sv
// mbc3 real time clock: register select, game writes,
// seconds prescaler and the rippling day counter

`timescale 1ns/100ps
`include "gb_cart_consts.svh"
`default_nettype none

module mbc3_rtc #(
	parameter int tick_cycles = `RTC_TICK_CYCLES
) (
	input  wire                          clk_sys,
	input  wire                          reset,
	input  wire                          ce,
	input  wire gb_cart_pkg::cart_addr_t cart_addr,
	input  wire                          cart_wr,
	input  wire  [7:0]                   cart_di,
	input  wire                          rtc_mode,
	input  wire gb_cart_pkg::rtc_sel_t   rtc_index,
	input  wire                          rtc_index_wr,
	output logic [7:0]                   rtc_data
);
	import gb_cart_pkg::*;

	localparam int tick_w = $clog2(tick_cycles + 1);

	rtc_sel_t          sel;
	logic [tick_w-1:0] tick_cnt;
	rtc_sec_t          rtc_sec, rtc_min;
	rtc_hour_t         rtc_hrs;
	rtc_day_t          rtc_days;
	logic              rtc_halt, rtc_ovf;
	logic              tick, game_wr;
	logic              sec_carry, min_carry, hrs_carry, day_carry;

	assign game_wr   = ce && cart_wr && rtc_mode && (cart_addr[15:13] == `REGION_CRAM);
	assign tick      = (tick_cnt == tick_w'(tick_cycles - 1));
	assign sec_carry = !rtc_halt && (rtc_sec >= 6'd60);
	assign min_carry = !rtc_halt && (rtc_min >= 6'd60);
	assign hrs_carry = !rtc_halt && (rtc_hrs >= 5'd24);
	assign day_carry = !rtc_halt && (rtc_days >= `RTC_MAX_DAYS);

	always_ff @(posedge clk_sys) begin
		if (reset)
			sel <= sel_sec;
		else if (rtc_index_wr)
			sel <= rtc_index;
	end

	// a seconds write restarts the running second
	always_ff @(posedge clk_sys) begin
		if (reset || tick || (game_wr && sel == sel_sec))
			tick_cnt <= '0;
		else
			tick_cnt <= tick_cnt + 1'b1;
	end

	// --------------------
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			{rtc_sec, rtc_min, rtc_hrs, rtc_days} <= '0;
			rtc_halt <= 1'b0;
			rtc_ovf  <= 1'b0;
		end else if (game_wr) begin
			case (sel)
				sel_sec:    rtc_sec <= cart_di[5:0];
				sel_min:    rtc_min <= cart_di[5:0];
				sel_hour:   rtc_hrs <= cart_di[4:0];
				sel_day_lo: rtc_days[7:0] <= cart_di;
				sel_day_hi: begin
					rtc_days[9:8] <= {1'b0, cart_di[0]};
					rtc_halt      <= cart_di[6];
					rtc_ovf       <= cart_di[7];    // game may clear the overflow
				end
				default: ;
			endcase
		end else begin
			if (sec_carry) begin
				rtc_sec <= '0;
				rtc_min <= rtc_min + 1'b1;
			end
			if (min_carry) begin
				rtc_min <= '0;
				rtc_hrs <= rtc_hrs + 1'b1;
			end
			if (hrs_carry) begin
				rtc_hrs  <= '0;
				rtc_days <= rtc_days + 1'b1;
			end
			if (day_carry) begin
				rtc_days <= '0;
				rtc_ovf  <= 1'b1;    // sticky
			end
			if (tick && !rtc_halt)
				rtc_sec <= rtc_sec + 1'b1;
		end
	end

	always_comb begin
		case (sel)
			sel_sec:    rtc_data = {2'b00, rtc_sec};
			sel_min:    rtc_data = {2'b00, rtc_min};
			sel_hour:   rtc_data = {3'b000, rtc_hrs};
			sel_day_lo: rtc_data = rtc_days[7:0];
			sel_day_hi: rtc_data = {rtc_ovf, rtc_halt, 5'b00000, rtc_days[8]};
			default:    rtc_data = 8'hFF;
		endcase
	end

	// each carry lands the field back in range by the next cycle
	a_sec_range: assert property (@(posedge clk_sys) disable iff (reset || game_wr)
		sec_carry |=> rtc_sec < 6'd60);
	a_min_range: assert property (@(posedge clk_sys) disable iff (reset || game_wr)
		min_carry |=> rtc_min < 6'd60);
	a_hrs_range: assert property (@(posedge clk_sys) disable iff (reset || game_wr)
		hrs_carry |=> rtc_hrs < 5'd24);

endmodule

`default_nettype wire

//--- src/mbc_ctrl.sv
// rom bank, ram bank, mbc1 mode, ram enable
// and mbc3 clock select registers of the mapper

`timescale 1ns/100ps
`include "gb_cart_consts.svh"
`default_nettype none

module mbc_ctrl (
	input  wire                           clk_sys,
	input  wire                           reset,
	input  wire                           ce,
	input  wire gb_cart_pkg::cart_addr_t  cart_addr,
	input  wire                           cart_wr,
	input  wire  [7:0]                    cart_di,
	input  wire gb_cart_pkg::mbc_kind_t   mbc_kind,
	output gb_cart_pkg::rom_bank_t        rom_bank,
	output gb_cart_pkg::ram_bank_t        ram_bank,
	output logic                          mbc1_mode,
	output logic                          ram_enable,
	output logic                          rtc_mode,
	output gb_cart_pkg::rtc_sel_t         rtc_index,
	output logic                          rtc_index_wr
);
	import gb_cart_pkg::*;

	logic       bus_wr;
	logic [2:0] region;
	logic       mbc1_or_2;

	assign bus_wr    = cart_wr && ce;
	assign region    = cart_addr[15:13];
	assign mbc1_or_2 = (mbc_kind == kind_mbc1) || (mbc_kind == kind_mbc2);

	always_ff @(posedge clk_sys) begin
		rtc_index_wr <= 1'b0;    // single cycle strobe
		if (reset) begin
			rom_bank   <= 9'd1;
			ram_bank   <= 4'd0;
			mbc1_mode  <= 1'b0;
			ram_enable <= 1'b0;
			rtc_mode   <= 1'b0;
		end else if (bus_wr) begin
			case (region)
				`REGION_RAM_EN: ram_enable <= (cart_di[3:0] == `RAM_ENABLE_KEY);

				// --------------------
				`REGION_ROM_BANK: begin
					if (mbc_kind == kind_mbc5) begin
						if (cart_addr[12])
							rom_bank[8] <= cart_di[0];       // 3xxx
						else
							rom_bank[7:0] <= cart_di;        // 2xxx
					end else if (cart_di[6:0] == 7'd0) begin
						rom_bank <= 9'd1;    // bank 0 cannot be mapped high
					end else if (mbc1_or_2 && cart_di[6:0] inside {7'h20, 7'h40, 7'h60}) begin
						rom_bank <= {2'b00, cart_di[6:0] | 7'h01};
					end else begin
						rom_bank <= {2'b00, cart_di[6:0]};
					end
				end

				// --------------------
				`REGION_RAM_BANK: begin
					if (mbc_kind == kind_mbc3) begin
						rtc_mode <= cart_di[3];    // 08-0C map a clock register
						if (cart_di[3]) begin
							rtc_index    <= rtc_sel_t'(cart_di[2:0]);
							rtc_index_wr <= 1'b1;
						end else begin
							ram_bank <= {2'b00, cart_di[1:0]};
						end
					end else if (mbc_kind == kind_mbc5) begin
						ram_bank <= cart_di[3:0];
					end else begin
						ram_bank <= {2'b00, cart_di[1:0]};    // mbc1 second bank field
					end
				end

				`REGION_MODE: if (mbc_kind == kind_mbc1) mbc1_mode <= cart_di[0];
				default: ;
			endcase
		end
	end

	// the bank register never moves to bank 0 outside mbc5
	a_rom_bank_nonzero: assert property (@(posedge clk_sys) disable iff (reset)
		(mbc_kind != kind_mbc5 && $changed(rom_bank)) |-> rom_bank != 9'd0);

endmodule

`default_nettype wire

//--- src/rom_bank_map.sv
// rom address mapping: bank select per mapper and
// masking to the rom size of the cartridge

`timescale 1ns/100ps
`include "gb_cart_consts.svh"
`default_nettype none

module rom_bank_map (
	input  wire gb_cart_pkg::cart_addr_t cart_addr,
	input  wire                          cart_rd,
	input  wire gb_cart_pkg::rom_bank_t  rom_bank,
	input  wire gb_cart_pkg::ram_bank_t  ram_bank,
	input  wire gb_cart_pkg::rom_bank_t  rom_mask,
	input  wire gb_cart_pkg::ram_bank_t  ram_mask,
	input  wire gb_cart_pkg::mbc_kind_t  mbc_kind,
	input  wire                          mbc1_mode,
	output gb_cart_pkg::rom_addr_t       rom_addr,
	output logic                         rom_rd
);
	import gb_cart_pkg::*;

	logic      low_half;      // 0000-3FFF
	logic [1:0] mbc1_bank2;
	rom_bank_t bank;

	assign low_half = ~cart_addr[14];

	// bank2 lines drive the ram chip instead when the ram is banked
	assign mbc1_bank2 = ram_bank[1:0] & {2{cart_addr[14] | mbc1_mode}} & ~ram_mask[1:0];

	always_comb begin
		case (mbc_kind)
			kind_mbc1: bank = {2'b00, mbc1_bank2, low_half ? 5'd0 : rom_bank[4:0]};
			kind_mbc2,
			kind_mbc3: bank = low_half ? 9'd0 : {2'b00, rom_bank[6:0]};
			kind_mbc5: bank = low_half ? 9'd0 : rom_bank;
			default:   bank = 9'd0;
		endcase
	end

	// --------------------
	always_comb begin
		if (mbc_kind == kind_none)
			rom_addr = {8'd0, cart_addr[14:0]};    // plain 32 KB cart
		else
			rom_addr = {bank & rom_mask, cart_addr[13:0]};
	end

	assign rom_rd = cart_rd && (cart_addr[15:13] != `REGION_CRAM);

endmodule

`default_nettype wire

//--- tests/gb_cart_stim.txt
# columns, all hex: test op addr data expected
# op 0 download word, 1 bus write, 2 read cart_do, 3 check rom_addr, 4 wait data cycles
01 0 000146 0100 000000
01 0 000148 0002 000000
01 1 002000 0000 000000
01 3 004000 0000 004000
01 1 002000 000D 000000
01 3 004000 0000 014000
01 3 001234 0000 001234
01 2 000001 0000 0000C3
01 2 000000 0000 0000A5
02 0 000146 1900 000000
02 0 000148 0008 000000
02 1 002000 00A5 000000
02 1 003000 0001 000000
02 3 004000 0000 694000
02 1 003000 0000 000000
02 1 002000 0000 000000
02 3 004000 0000 000000
03 0 000146 1B00 000000
03 0 000148 0308 000000
03 2 00A010 0000 0000FF
03 1 000000 000A 000000
03 1 004000 0002 000000
03 1 00A010 005A 000000
03 2 00A010 0000 00005A
03 1 004000 0001 000000
03 1 00A010 003C 000000
03 2 00A010 0000 00003C
03 1 004000 0002 000000
03 2 00A010 0000 00005A
03 1 000000 0000 000000
03 2 00A010 0000 0000FF
04 0 000146 0500 000000
04 0 000148 0002 000000
04 1 000000 000A 000000
04 1 00A123 007B 000000
04 2 00A123 0000 0000FB
04 2 00A323 0000 0000FB
05 0 000146 1000 000000
05 0 000148 0302 000000
05 1 000000 000A 000000
05 1 004000 0008 000000
05 4 000000 0001 000000
05 1 00A000 003B 000000
05 2 00A000 0000 00003B
05 4 000000 0010 000000
05 2 00A000 0000 000000
05 1 004000 0009 000000
05 2 00A000 0000 000001
06 1 004000 000C 000000
06 4 000000 0001 000000
06 1 00A000 0040 000000
06 1 004000 0008 000000
06 4 000000 0001 000000
06 1 00A000 0005 000000
06 2 00A000 0000 000005
06 4 000000 0028 000000
06 2 00A000 0000 000005
06 1 004000 000C 000000
06 2 00A000 0000 000040
06 1 004000 0001 000000
06 2 00A010 0000 00003C
06 1 00A020 0099 000000
06 2 00A020 0000 000099

//--- tests/tb_gb_cart.sv
// cartridge mapper testbench with stimulus file reader,
// bus and download drivers, checks, watchdog and report

`timescale 1ns/100ps
`default_nettype none

module tb_gb_cart;

	localparam int clk_period    = 40;
	localparam int reset_cycles  = 5;
	localparam int margin_cycles = 100;

	// operation codes in the stimulus file
	localparam int op_download = 0;
	localparam int op_write    = 1;
	localparam int op_read     = 2;
	localparam int op_addr     = 3;
	localparam int op_wait     = 4;

	logic        clk_sys;
	logic        reset;
	logic        ce;
	logic [15:0] cart_addr;
	logic        cart_rd;
	logic        cart_wr;
	logic [7:0]  cart_di;
	logic [15:0] rom_data;
	logic        dl_active;
	logic        dl_wr;
	logic [23:0] dl_addr;
	logic [15:0] dl_data;
	logic [22:0] rom_addr;
	logic        rom_rd;
	logic [7:0]  cart_do;

	logic [31:0] test_q[$];
	logic [31:0] op_q[$];
	logic [31:0] addr_q[$];
	logic [31:0] data_q[$];
	logic [31:0] exp_q[$];

	logic [31:0] cur_test;
	int          test_checks, test_errors;
	int          total_checks, total_errors, tests_done;
	longint      budget_cycles;
	logic        stim_loaded;

	gb_cart #(.tick_cycles(16)) i_dut (
		.clk_sys(clk_sys), .reset(reset), .ce(ce), .cart_addr(cart_addr),
		.cart_rd(cart_rd), .cart_wr(cart_wr), .cart_di(cart_di), .rom_data(rom_data),
		.dl_active(dl_active), .dl_wr(dl_wr), .dl_addr(dl_addr), .dl_data(dl_data),
		.rom_addr(rom_addr), .rom_rd(rom_rd), .cart_do(cart_do)
	);

	always #(clk_period / 2) clk_sys = ~clk_sys;

	// --------------------
	task automatic load_stimulus();
		int          fd;
		int          n;
		string       line;
		logic [31:0] t, o, a, d, e;
		fd = $fopen("tests/gb_cart_stim.txt", "r");
		if (fd == 0) begin
			$display("cannot open the stimulus file tests/gb_cart_stim.txt");
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() > 1 && line[0] != "#") begin    // skip blanks and comments
				n = $sscanf(line, "%h %h %h %h %h", t, o, a, d, e);
				if (n == 5) begin
					test_q.push_back(t);
					op_q.push_back(o);
					addr_q.push_back(a);
					data_q.push_back(d);
					exp_q.push_back(e);
				end
			end
		end
		$fclose(fd);
	endtask

	// all drivers start and end on a falling edge
	task automatic download_word(input logic [23:0] addr, input logic [15:0] data);
		dl_active = 1'b1;
		dl_wr     = 1'b1;
		dl_addr   = addr;
		dl_data   = data;
		@(negedge clk_sys);
		dl_wr     = 1'b0;
		dl_active = 1'b0;
	endtask

	task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
		cart_addr = addr;
		cart_di   = data;
		cart_wr   = 1'b1;
		ce        = 1'b1;
		@(negedge clk_sys);
		cart_wr   = 1'b0;
		ce        = 1'b0;
	endtask

	task automatic check_read(input logic [15:0] addr, input logic [7:0] expected);
		logic exp_rd;
		exp_rd    = !(addr >= 16'hA000 && addr <= 16'hBFFF);    // external rom outside A000-BFFF
		cart_addr = addr;
		cart_rd   = 1'b1;
		@(negedge clk_sys);    // ram data lands one edge later
		test_checks += 2;
		assert (cart_do === expected) else begin
			$display("MISMATCH test %0h cart_do at %04h: got %02h expected %02h",
				cur_test, addr, cart_do, expected);
			test_errors++;
		end
		assert (rom_rd === exp_rd) else begin
			$display("MISMATCH test %0h rom_rd at %04h: got %h expected %h",
				cur_test, addr, rom_rd, exp_rd);
			test_errors++;
		end
		cart_rd = 1'b0;
	endtask

	task automatic check_rom_addr(input logic [15:0] addr, input logic [22:0] expected);
		cart_addr = addr;
		cart_rd   = 1'b1;
		@(negedge clk_sys);
		test_checks += 2;
		assert (rom_addr === expected) else begin
			$display("MISMATCH test %0h rom_addr at %04h: got %06h expected %06h",
				cur_test, addr, rom_addr, expected);
			test_errors++;
		end
		assert (rom_rd === 1'b1) else begin
			$display("MISMATCH test %0h rom_rd at %04h: got %h expected 1",
				cur_test, addr, rom_rd);
			test_errors++;
		end
		cart_rd = 1'b0;
	endtask

	task automatic run_op(input logic [31:0] op, addr, data, expected);
		case (op)
			op_download: download_word(addr[23:0], data[15:0]);
			op_write:    bus_write(addr[15:0], data[7:0]);
			op_read:     check_read(addr[15:0], expected[7:0]);
			op_addr:     check_rom_addr(addr[15:0], expected[22:0]);
			op_wait:     repeat (data) @(negedge clk_sys);
			default: begin
				$display("unknown operation %0h in test %0h", op, cur_test);
				test_errors++;
			end
		endcase
	endtask

	task automatic finish_test();
		$display("test %0h done: %0d checks, %0d errors", cur_test, test_checks, test_errors);
		total_checks += test_checks;
		total_errors += test_errors;
		test_checks   = 0;
		test_errors   = 0;
		tests_done++;
	endtask

	// --------------------
	initial begin
		clk_sys   = 1'b0;
		reset     = 1'b1;
		ce        = 1'b0;
		cart_addr = 16'h0000;
		cart_rd   = 1'b0;
		cart_wr   = 1'b0;
		cart_di   = 8'h00;
		rom_data  = 16'hC3A5;    // bit 0 of cart_addr picks a byte of this word
		dl_active = 1'b0;
		dl_wr     = 1'b0;
		dl_addr   = 24'h000000;
		dl_data   = 16'h0000;
		stim_loaded  = 1'b0;
		test_checks  = 0;
		test_errors  = 0;
		total_checks = 0;
		total_errors = 0;
		tests_done   = 0;
		cur_test     = 0;
		load_stimulus();
		budget_cycles = reset_cycles + margin_cycles;
		foreach (op_q[i])
			budget_cycles += (op_q[i] == op_wait) ? data_q[i] : 1;
		stim_loaded = 1'b1;
		repeat (reset_cycles) @(negedge clk_sys);
		reset = 1'b0;
		if (op_q.size() == 0) begin
			$display("no operations were read from the stimulus file");
			total_errors++;
		end else begin
			cur_test = test_q[0];
		end
		foreach (op_q[i]) begin
			if (test_q[i] != cur_test) begin
				finish_test();
				cur_test = test_q[i];
			end
			run_op(op_q[i], addr_q[i], data_q[i], exp_q[i]);
		end
		if (op_q.size() != 0)
			finish_test();
		$display("%0d tests, %0d checks, %0d errors", tests_done, total_checks, total_errors);
		if (total_errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

	// watchdog sized from the stimulus length
	initial begin
		wait (stim_loaded === 1'b1);
		#(budget_cycles * clk_period);
		$display("watchdog expired after %0d cycles, the run did not complete", budget_cycles);
		$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire
